// ==== logic/game_pkg.sv ====
package game_pkg;

  // well geometry
  localparam int well_w  = 10;
  localparam int well_h  = 20;
  localparam int x_bits  = 4;
  localparam int y_bits  = 5;
  localparam int spawn_x = 4;

  localparam int gravity_div  = 2 ** 20;  // roughly 21 ms at 50 MHz
  localparam int gravity_bits = $clog2(gravity_div);
  localparam int queue_depth  = 4;
  localparam int q_bits       = $clog2(queue_depth);

  // ascii for the lcd rows
  localparam logic [7:0]   asc_zero  = 8'h30;
  localparam logic [7:0]   asc_alpha = 8'h37;  // "A" minus ten
  localparam logic [7:0]   asc_space = 8'h20;
  localparam logic [127:0] row_init  = "????????????????";
  localparam logic [71:0]  over_text = "GAME OVER";

  typedef enum logic [2:0] {
    cmd_none, cmd_left, cmd_right, cmd_down, cmd_drop, cmd_tick
  } opcode_e;

  typedef enum logic [2:0] {
    st_idle, st_move, st_scan, st_land, st_clear, st_over
  } state_e;

  typedef logic [2:0] kind_t;    // 0 is an empty cell
  typedef logic [15:0] score_t;  // four bcd digits

  typedef struct packed {
    opcode_e op;
    logic    valid;
  } cmd_t;

  typedef struct packed {
    state_e  state;
    score_t  score;
    opcode_e last_op;
    logic    over;
  } game_status_t;

  // one nibble as an ascii hex digit
  function automatic logic [7:0] hex_char(input logic [3:0] n);
    return {4'h0, n} + ((n < 4'd10) ? asc_zero : asc_alpha);
  endfunction

endpackage

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/100ps

module cmd_decoder import game_pkg::*; (
  input  logic       clk_50MHz,
  input  logic       reset_n,
  input  logic [3:0] btn,        // left, right, down, drop
  input  logic       gravity_en,
  output cmd_t       push
);

  logic [3:0]              btn_r1;
  logic [3:0]              btn_r2;
  logic [3:0]              btn_rise;
  logic [gravity_bits-1:0] grav_cnt;
  logic                    grav_tick;
  cmd_t                    next_cmd;

  assign btn_rise  = btn_r1 & ~btn_r2;
  assign grav_tick = gravity_en && (grav_cnt == gravity_bits'(gravity_div - 1));

  // fixed priority, lowest button index first
  always_comb begin
    next_cmd = '{op: cmd_none, valid: 1'b0};
    if (btn_rise[0])
      next_cmd = '{op: cmd_left, valid: 1'b1};
    else if (btn_rise[1])
      next_cmd = '{op: cmd_right, valid: 1'b1};
    else if (btn_rise[2])
      next_cmd = '{op: cmd_down, valid: 1'b1};
    else if (btn_rise[3])
      next_cmd = '{op: cmd_drop, valid: 1'b1};
    else if (grav_tick && !push.valid)  // tick right after a strobe is lost
      next_cmd = '{op: cmd_tick, valid: 1'b1};
  end

  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      btn_r1   <= '0;
      btn_r2   <= '0;
      grav_cnt <= '0;
      push     <= '{op: cmd_none, valid: 1'b0};
    end else begin
      btn_r1 <= btn;
      btn_r2 <= btn_r1;
      push   <= next_cmd;  // strobe lands two edges after the press
      if (!gravity_en || grav_tick)
        grav_cnt <= '0;
      else
        grav_cnt <= grav_cnt + 1'b1;
    end
  end

  // debounced buttons never give strobes back to back
  push_single_cycle: assert property (
    @(posedge clk_50MHz) disable iff (!reset_n)
    push.valid |=> !push.valid
  );

endmodule

// ==== logic/cmd_queue.sv ====
`timescale 1ns/100ps

module cmd_queue import game_pkg::*; (
  input  logic clk_50MHz,
  input  logic reset_n,
  input  cmd_t push,
  input  logic pop,
  output cmd_t head,
  output logic overflow
);

  cmd_t              mem [queue_depth];
  logic [q_bits-1:0] wr_ptr;
  logic [q_bits-1:0] rd_ptr;
  logic [q_bits:0]   count;
  logic              full;
  logic              do_push;
  logic              do_pop;

  assign full    = (count == (q_bits + 1)'(queue_depth));
  assign do_pop  = pop && (count != '0);
  assign do_push = push.valid && (!full || do_pop);  // a pop frees the slot this cycle

  assign head = '{op: mem[rd_ptr].op, valid: (count != '0)};

  always_ff @(posedge clk_50MHz) begin
    if (do_push)
      mem[wr_ptr] <= push;
  end

  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // pointers wrap, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push.valid && !do_push)
        overflow <= 1'b1;  // sticky
    end
  end

  // the engine only pops what it saw as a valid head
  no_pop_when_empty: assert property (
    @(posedge clk_50MHz) disable iff (!reset_n)
    pop |-> (count != '0)
  );

endmodule

// ==== logic/well_engine.sv ====
`timescale 1ns/100ps

module well_engine import game_pkg::*; (
  input  logic              clk_50MHz,
  input  logic              reset_n,
  input  cmd_t              head,
  output logic              pop,
  input  logic [x_bits-1:0] qx,
  input  logic [y_bits-1:0] qy,
  output kind_t             q_kind,
  output game_status_t      status
);

  typedef kind_t [well_w-1:0] row_t;

  row_t              well [well_h];  // row 0 is the top
  state_e            state;
  opcode_e           cur_op;
  opcode_e           last_op;
  logic [x_bits-1:0] cur_x;
  logic [y_bits-1:0] cur_y;
  kind_t             cur_kind;
  kind_t             next_kind;
  logic [x_bits-1:0] col;
  logic [y_bits-1:0] row_sel;
  logic              row_full;
  logic              shifting;
  score_t            score;
  logic              left_free;
  logic              right_free;
  logic              below_free;
  logic              spawn_busy;

  function automatic score_t bcd_inc(input score_t s);
    score_t r;
    logic   carry;
    r     = s;
    carry = 1'b1;
    for (int d = 0; d < 4; d++) begin
      if (carry) begin
        if (r[4*d +: 4] == 4'd9) begin
          r[4*d +: 4] = 4'd0;
        end else begin
          r[4*d +: 4] = r[4*d +: 4] + 4'd1;
          carry       = 1'b0;
        end
      end
    end
    return r;
  endfunction

  assign pop        = (state == st_idle) && head.valid;
  assign next_kind  = (cur_kind == kind_t'(7)) ? kind_t'(1) : cur_kind + 1'b1;
  assign left_free  = (cur_x != '0) && (well[cur_y][cur_x - 1'b1] == '0);
  assign right_free = (cur_x != x_bits'(well_w - 1)) && (well[cur_y][cur_x + 1'b1] == '0);
  assign below_free = (cur_y != y_bits'(well_h - 1)) && (well[cur_y + 1'b1][cur_x] == '0);
  assign spawn_busy = (well[0][spawn_x] != '0);

  assign status = '{state: state, score: score, last_op: last_op, over: (state == st_over)};

  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      well     <= '{default: '0};
      state    <= st_idle;
      cur_op   <= cmd_none;
      last_op  <= cmd_none;
      cur_x    <= x_bits'(spawn_x);
      cur_y    <= '0;
      cur_kind <= kind_t'(1);
      col      <= '0;
      row_sel  <= '0;
      row_full <= 1'b0;
      shifting <= 1'b0;
      score    <= '0;
    end else begin
      case (state)
        st_idle: if (pop) begin
          cur_op  <= head.op;
          last_op <= head.op;
          state   <= (head.op == cmd_drop) ? st_scan : st_move;
        end
        st_move: begin
          state <= st_idle;
          case (cur_op)
            cmd_left:  if (left_free) cur_x <= cur_x - 1'b1;
            cmd_right: if (right_free) cur_x <= cur_x + 1'b1;
            cmd_down, cmd_tick: begin
              if (below_free)
                cur_y <= cur_y + 1'b1;
              else
                state <= st_land;  // blocked, so the cell lands here
            end
            default: ;
          endcase
        end
        st_scan: begin
          if (below_free)
            cur_y <= cur_y + 1'b1;  // one row per cycle
          else
            state <= st_land;
        end
        st_land: begin
          well[cur_y][cur_x] <= cur_kind;
          row_sel  <= cur_y;
          col      <= '0;
          row_full <= 1'b1;
          shifting <= 1'b0;
          state    <= st_clear;
        end
        st_clear: begin
          if (!shifting) begin
            // walk the landed row a cell at a time
            if (well[row_sel][col] == '0)
              row_full <= 1'b0;
            if (col != x_bits'(well_w - 1)) begin
              col <= col + 1'b1;
            end else if (row_full && well[row_sel][col] != '0) begin
              shifting <= 1'b1;
              score    <= bcd_inc(score);
            end else if (spawn_busy) begin
              state <= st_over;
            end else begin
              cur_x    <= x_bits'(spawn_x);
              cur_y    <= '0;
              cur_kind <= next_kind;
              state    <= st_idle;
            end
          end else if (row_sel == '0) begin
            well[0]  <= '0;
            shifting <= 1'b0;
            row_full <= 1'b0;  // falls through to the spawn next cycle
          end else begin
            well[row_sel] <= well[row_sel - 1'b1];
            row_sel       <= row_sel - 1'b1;
          end
        end
        st_over: ;  // held until reset
        default: state <= st_idle;
      endcase
    end
  end

  // cell query for the renderer, falling cell drawn on top
  always_ff @(posedge clk_50MHz) begin
    if (qx >= x_bits'(well_w) || qy >= y_bits'(well_h))
      q_kind <= '0;
    else if (qx == cur_x && qy == cur_y)
      q_kind <= cur_kind;
    else
      q_kind <= well[qy][qx];
  end

  // landing and spawning never leave the live cell on a filled one
  falling_cell_free: assert property (
    @(posedge clk_50MHz) disable iff (!reset_n)
    (state == st_idle) |-> (well[cur_y][cur_x] == '0)
  );

endmodule

// ==== logic/status_text.sv ====
`timescale 1ns/100ps

module status_text import game_pkg::*; (
  input  logic         clk_50MHz,
  input  logic         reset_n,
  input  game_status_t status,
  output logic [127:0] row_a,
  output logic [127:0] row_b
);

  logic [7:0]  st_code;
  logic [7:0]  op_code;
  logic [71:0] over_field;

  assign st_code    = 8'(status.state);
  assign op_code    = 8'(status.last_op);
  assign over_field = status.over ? over_text : {9{asc_space}};

  // leftmost character sits in the top byte
  always_ff @(posedge clk_50MHz) begin
    if (!reset_n) begin
      row_a <= row_init;
      row_b <= row_init;
    end else begin
      row_a <= {hex_char(st_code[7:4]), hex_char(st_code[3:0]), asc_space,
                over_field, {4{asc_space}}};
      row_b <= {hex_char(op_code[7:4]), hex_char(op_code[3:0]), asc_space,
                hex_char(status.score[15:12]),
                hex_char(status.score[11:8]),
                hex_char(status.score[7:4]),
                hex_char(status.score[3:0]),
                {9{asc_space}}};
    end
  end

endmodule

// ==== logic/game_core.sv ====
`timescale 1ns/100ps

module game_core import game_pkg::*; (
  input  logic              clk_50MHz,
  input  logic              reset_n,
  input  logic [3:0]        btn,
  input  logic              gravity_en,
  input  logic [x_bits-1:0] qx,
  input  logic [y_bits-1:0] qy,
  output kind_t             q_kind,
  output game_status_t      status,
  output logic [127:0]      row_a,
  output logic [127:0]      row_b,
  output logic              overflow
);

  cmd_t push;
  cmd_t head;
  logic pop;

  cmd_decoder decoder_i (
    .clk_50MHz  (clk_50MHz),
    .reset_n    (reset_n),
    .btn        (btn),
    .gravity_en (gravity_en),
    .push       (push)
  );

  cmd_queue queue_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .push      (push),
    .pop       (pop),
    .head      (head),
    .overflow  (overflow)
  );

  well_engine engine_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .head      (head),
    .pop       (pop),
    .qx        (qx),
    .qy        (qy),
    .q_kind    (q_kind),
    .status    (status)
  );

  status_text text_i (
    .clk_50MHz (clk_50MHz),
    .reset_n   (reset_n),
    .status    (status),
    .row_a     (row_a),
    .row_b     (row_b)
  );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic clk_50MHz,
  output logic reset_n
);

  initial begin
    clk_50MHz = 1'b0;
    forever #10 clk_50MHz = ~clk_50MHz;  // 20 ns period
  end

  // reset held low over the first three rising edges
  initial begin
    reset_n = 1'b0;
    repeat (3) @(posedge clk_50MHz);
    #1 reset_n = 1'b1;
  end

endmodule

// ==== sim/tb_game_core.sv ====
`timescale 1ns/100ps

module tb_game_core import game_pkg::*; ();

  logic              clk_50MHz;
  logic              reset_n;
  logic [3:0]        btn;
  logic              gravity_en;
  logic [x_bits-1:0] qx;
  logic [y_bits-1:0] qy;
  kind_t             q_kind;
  game_status_t      status;
  logic [127:0]      row_a;
  logic [127:0]      row_b;
  logic              overflow;
  logic [127:0]      exp_row;

  int model [well_h][well_w];  // expected well, row 0 on top
  int mx, my, mk, mscore;      // expected falling cell and score
  bit mover;
  int errors, err_mark, tests_run, tests_failed, n;

  tb_clock clock_i (.clk_50MHz(clk_50MHz), .reset_n(reset_n));

  game_core dut_i (
    .clk_50MHz  (clk_50MHz),
    .reset_n    (reset_n),
    .btn        (btn),
    .gravity_en (gravity_en),
    .qx         (qx),
    .qy         (qy),
    .q_kind     (q_kind),
    .status     (status),
    .row_a      (row_a),
    .row_b      (row_b),
    .overflow   (overflow)
  );

  function automatic logic [7:0] ascii_hex_digit(input int v);
    return (v < 10) ? 8'(8'h30 + v) : 8'(8'h41 + v - 10);
  endfunction

  function automatic logic [15:0] to_bcd(input int v);
    logic [15:0] r;
    for (int i = 0; i < 4; i++)
      r[4*i +: 4] = 4'((v / (10 ** i)) % 10);
    return r;
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // one press lasts a single cycle
  task automatic press(input int b);
    @(posedge clk_50MHz);
    #1 btn = 4'b0001 << b;
    @(posedge clk_50MHz);
    #1 btn = 4'b0000;
  endtask

  task automatic wait_busy();
    int t = 0;
    while (status.state == st_idle && t < 200) begin
      @(posedge clk_50MHz);
      #1 t++;
    end
    if (t == 200) begin
      $display("timeout: the engine never picked up a command in 200 cycles");
      $display("Finished with errors");
      $finish;
    end
  endtask

  task automatic wait_idle();
    int t = 0;
    while (status.state != st_idle && status.state != st_over && t < 200) begin
      @(posedge clk_50MHz);
      #1 t++;
    end
    if (t == 200) begin
      $display("timeout: the engine did not return to idle within 200 cycles");
      $display("Finished with errors");
      $finish;
    end
  endtask

  // land the expected cell, clear a full row, then spawn
  task automatic drop_model();
    bit full;
    full = 1'b1;
    while (my < well_h - 1 && model[my+1][mx] == 0)
      my++;
    model[my][mx] = mk;
    for (int x = 0; x < well_w; x++)
      if (model[my][x] == 0)
        full = 1'b0;
    if (full) begin
      for (int y = my; y > 0; y--)
        for (int x = 0; x < well_w; x++)
          model[y][x] = model[y-1][x];
      for (int x = 0; x < well_w; x++)
        model[0][x] = 0;
      mscore++;
    end
    if (model[0][spawn_x] != 0) begin
      mover = 1'b1;  // cell stays where it landed
    end else begin
      mx = spawn_x;
      my = 0;
      mk = (mk == 7) ? 1 : mk + 1;
    end
  endtask

  task automatic do_cmd(input int b);
    press(b);
    wait_busy();
    wait_idle();
    if (b == 0 && mx > 0 && model[my][mx-1] == 0)
      mx--;
    else if (b == 1 && mx < well_w - 1 && model[my][mx+1] == 0)
      mx++;
    else if (b == 3)
      drop_model();
  endtask

  task automatic drop_at(input int x);
    while (mx > x)
      do_cmd(0);
    while (mx < x)
      do_cmd(1);
    do_cmd(3);
  endtask

  task automatic check_well();
    int exp;
    for (int y = 0; y < well_h; y++) begin
      for (int x = 0; x < well_w; x++) begin
        exp = (x == mx && y == my) ? mk : model[y][x];
        qx  = x_bits'(x);
        qy  = y_bits'(y);
        @(posedge clk_50MHz);
        #1;
        assert (q_kind == exp) else begin
          $display("FAIL %0t q_kind at (%0d,%0d): got %0d, expected %0d",
                   $time, x, y, q_kind, exp);
          errors++;
        end
      end
    end
  endtask

  // first two lcd characters of row a carry the state code
  task automatic check_state_code(input int code);
    logic [15:0] exp;
    exp = {ascii_hex_digit(code / 16), ascii_hex_digit(code % 16)};
    assert (row_a[127:112] == exp) else begin
      $display("FAIL %0t row_a state code: got \"%s\", expected \"%s\"",
               $time, row_a[127:112], exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    btn          = 4'b0000;
    gravity_en   = 1'b0;  // no gravity ticks in these tests
    qx           = '0;
    qy           = '0;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    model        = '{default: 0};
    mx           = spawn_x;
    my           = 0;
    mk           = 1;
    mscore       = 0;
    mover        = 1'b0;
    repeat (5) @(posedge clk_50MHz);
    #1;

    check_well();
    check_val("score", status.score, 0);
    check_val("state", status.state, st_idle);
    check_val("overflow", overflow, 0);
    end_test("after reset");

    repeat (6) begin
      do_cmd(0);
      check_well();
    end
    repeat (11) begin
      do_cmd(1);
      check_well();
    end
    end_test("moves");

    repeat (8)
      drop_at(well_w - 1);  // kinds wrap after 7
    check_well();
    end_test("drop and stacking");

    for (int x = 0; x < well_w - 1; x++)
      drop_at(x);
    check_well();
    check_val("score", status.score, to_bcd(mscore));
    check_val("score", status.score, 16'h0001);
    end_test("row clear and score");

    check_state_code(int'(st_idle));
    exp_row = {ascii_hex_digit(0), ascii_hex_digit(int'(cmd_drop)), 8'h20,
               ascii_hex_digit(mscore / 1000 % 10), ascii_hex_digit(mscore / 100 % 10),
               ascii_hex_digit(mscore / 10 % 10), ascii_hex_digit(mscore % 10),
               {9{8'h20}}};
    assert (row_b == exp_row) else begin
      $display("FAIL %0t row_b: got \"%s\", expected \"%s\"", $time, row_b, exp_row);
      errors++;
    end
    check_val("overflow", overflow, 0);
    repeat (6)
      press(3);  // faster than the engine drains
    repeat (queue_depth + 1) begin
      wait_busy();
      wait_idle();
      drop_model();
    end
    check_val("overflow", overflow, 1);
    check_well();
    end_test("status text and overflow");

    n = 0;
    while (!mover && n < well_h) begin
      do_cmd(3);
      n++;
    end
    check_val("state", status.state, st_over);
    check_val("over", status.over, 1);
    press(0);
    press(3);
    repeat (10) @(posedge clk_50MHz);
    #1;
    check_val("state", status.state, st_over);
    check_state_code(int'(st_over));
    check_well();
    end_test("game over");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sources.f ====
logic/game_pkg.sv
logic/cmd_decoder.sv
logic/cmd_queue.sv
logic/well_engine.sv
logic/status_text.sv
logic/game_core.sv
sim/tb_clock.sv
sim/tb_game_core.sv
